// ==== verilog/soc_bus_pkg.sv ====
// SoC bus shared definitions
`default_nettype none

package soc_bus_pkg;

  // Bus widths
  localparam int DATA_W = 16;
  localparam int ADR_W  = 19;                     // Word address, bits 19:1
  localparam int SEL_W  = 2;                      // One select per byte lane

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADR_W-1:0]  addr_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // Interrupts
  localparam int IRQ_N = 8;                       // Interrupt request lines

  typedef logic [2:0] irq_id_t;

  localparam data_t VECTOR_BASE = 16'd8;          // First vector of the controller

  // Unmapped accesses read back as all ones
  localparam data_t DEFAULT_DATA = 16'hffff;

  // GPIO occupies I/O 0xf100 to 0xf103, which are word addresses 0x7880 and 0x7881.
  // I/O space is only 16 bits wide, so the mask ignores the upper address bits.
  localparam addr_t GPIO_IO_ADDR = 19'h07880;
  localparam addr_t GPIO_IO_MASK = 19'h07ffe;     // Word bit 0 picks the register

  // Target of the current bus access
  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_GPIO,
    SEL_DEFAULT
  } slave_sel_e;

endpackage

`default_nettype wire

// ==== verilog/rst_stretch.sv ====
// Power-on reset stretcher
`timescale 1ns/1ps
`default_nettype none

module rst_stretch #(
  parameter int RST_CNT_W = 17                    // Hold time is 2**RST_CNT_W - 1 cycles
) (
  input  logic clk,
  input  logic rst_lck,                           // Low while the clock is not stable
  output logic sys_rst_o
);

  logic [RST_CNT_W-1:0] cnt_q;                    // Debounce counter

  // A low lock input reloads the counter, so glitches restart the whole wait
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q     <= '1;
      sys_rst_o <= 1'b1;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      sys_rst_o <= (cnt_q != '0);                 // Released once the count runs out
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wb_addr_decode.sv ====
// Wishbone address decoder and bus switch
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode #(
  parameter int RAM_AW = 10                       // RAM word address width
) (
  input  logic                  clk,
  input  logic                  sys_rst_i,

  // Master side
  input  soc_bus_pkg::addr_t    adr_i,
  input  logic                  tga_i,            // High for I/O space
  input  soc_bus_pkg::sel_t     sel_i,
  input  logic                  we_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  output soc_bus_pkg::data_t    dat_o,
  output logic                  ack_o,

  // Slave strobes
  output logic                  ram_stb_o,
  output logic                  gpio_stb_o,

  // Slave returns
  input  soc_bus_pkg::data_t    ram_dat_i,
  input  logic                  ram_ack_i,
  input  soc_bus_pkg::data_t    gpio_dat_i,
  input  logic                  gpio_ack_i,

  // Interrupt acknowledge
  input  logic                  inta_i,
  input  soc_bus_pkg::irq_id_t  irq_id_i
);

  soc_bus_pkg::slave_sel_e slave_sel;
  soc_bus_pkg::data_t      bus_dat;
  soc_bus_pkg::data_t      vector;
  logic                    bus_open_q;            // Bus accepts accesses
  logic                    req;
  logic                    ram_hit;
  logic                    gpio_hit;
  logic                    def_ack;
  logic                    bus_ack;

  // Nothing is accepted until the stretched reset has ended
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      bus_open_q <= 1'b0;
    end else begin
      bus_open_q <= 1'b1;
    end
  end

  assign req = cyc_i & stb_i & bus_open_q;

  assign ram_hit  = !tga_i && ((adr_i >> RAM_AW) == '0);  // Memory below the RAM size
  assign gpio_hit = tga_i &&
                    ((adr_i & soc_bus_pkg::GPIO_IO_MASK) ==
                     (soc_bus_pkg::GPIO_IO_ADDR & soc_bus_pkg::GPIO_IO_MASK));

  // An access with no byte lane selected has nothing to transfer,
  // so it goes to the default slave as well
  always_comb begin
    slave_sel = soc_bus_pkg::SEL_DEFAULT;
    if (sel_i != '0) begin
      if (ram_hit) begin
        slave_sel = soc_bus_pkg::SEL_RAM;
      end else if (gpio_hit) begin
        slave_sel = soc_bus_pkg::SEL_GPIO;
      end
    end
  end

  assign ram_stb_o  = req && (slave_sel == soc_bus_pkg::SEL_RAM);
  assign gpio_stb_o = req && (slave_sel == soc_bus_pkg::SEL_GPIO);
  assign def_ack    = req && (slave_sel == soc_bus_pkg::SEL_DEFAULT);  // Zero wait states

  always_comb begin
    case (slave_sel)
      soc_bus_pkg::SEL_RAM: begin
        bus_dat = ram_dat_i;
        bus_ack = ram_ack_i;
      end
      soc_bus_pkg::SEL_GPIO: begin
        bus_dat = gpio_dat_i;
        bus_ack = gpio_ack_i;
      end
      default: begin
        bus_dat = we_i ? '0 : soc_bus_pkg::DEFAULT_DATA;  // Writes are dropped
        bus_ack = def_ack;
      end
    endcase
  end

  assign vector = soc_bus_pkg::VECTOR_BASE + soc_bus_pkg::data_t'(irq_id_i);

  assign dat_o = inta_i ? vector : bus_dat;       // Vector replaces bus data
  assign ack_o = bus_ack;

endmodule

`default_nettype wire

// ==== verilog/base_ram.sv ====
// Wishbone block RAM
`timescale 1ns/1ps
`default_nettype none

module base_ram #(
  parameter int RAM_AW = 10                       // Word address width
) (
  input  logic               clk,
  input  logic               sys_rst_i,
  input  logic [RAM_AW-1:0]  adr_i,
  input  soc_bus_pkg::data_t dat_i,
  input  soc_bus_pkg::sel_t  sel_i,
  input  logic               we_i,
  input  logic               cyc_i,
  input  logic               stb_i,
  output soc_bus_pkg::data_t dat_o,
  output logic               ack_o
);

  soc_bus_pkg::data_t mem [2**RAM_AW];

  logic access;

  // The master holds stb through the ack cycle, so a set ack blocks a second hit
  assign access = cyc_i & stb_i & !ack_o;

  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;                            // Single cycle ack
    end
  end

  // Byte lanes are written separately
  always_ff @(posedge clk) begin
    if (access && we_i) begin
      for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
        if (sel_i[b]) begin
          mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= mem[adr_i];                        // Valid with ack
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gpio_port.sv ====
// Switch and LED port
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
  input  logic               clk,
  input  logic               sys_rst_i,
  input  logic               adr_i,               // Word 0 switches, word 1 LEDs
  input  soc_bus_pkg::data_t dat_i,
  input  soc_bus_pkg::sel_t  sel_i,
  input  logic               we_i,
  input  logic               cyc_i,
  input  logic               stb_i,
  output soc_bus_pkg::data_t dat_o,
  output logic               ack_o,
  input  logic [9:0]         sw_i,
  output logic [9:0]         led_o
);

  logic [9:0] sw_q;
  logic       access;

  assign access = cyc_i & stb_i & !ack_o;

  always_ff @(posedge clk) begin
    sw_q <= sw_i;                                 // Sample the switch pins
  end

  // LED bits 7:0 sit in the low lane, bits 9:8 in the high lane
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      ack_o <= 1'b0;
      led_o <= '0;
    end else begin
      ack_o <= access;
      if (access && we_i && adr_i) begin
        if (sel_i[0]) led_o[7:0] <= dat_i[7:0];
        if (sel_i[1]) led_o[9:8] <= dat_i[9:8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= adr_i ? {6'b0, led_o} : {6'b0, sw_q};  // Switches are read-only
    end
  end

endmodule

`default_nettype wire

// ==== verilog/int_ctrl.sv ====
// Priority interrupt controller
`timescale 1ns/1ps
`default_nettype none

module int_ctrl (
  input  logic                           clk,
  input  logic                           sys_rst_i,
  input  logic [soc_bus_pkg::IRQ_N-1:0]  irq_i,
  input  logic                           inta_i,      // Acknowledge of irq_id_o
  output logic                           intr_o,
  output soc_bus_pkg::irq_id_t           irq_id_o
);

  logic [soc_bus_pkg::IRQ_N-1:0] irq_q;            // Lines one cycle ago
  logic [soc_bus_pkg::IRQ_N-1:0] pend_q;
  logic [soc_bus_pkg::IRQ_N-1:0] rise;
  logic [soc_bus_pkg::IRQ_N-1:0] clr;

  assign rise = irq_i & ~irq_q;

  // Lowest index has the highest priority
  always_comb begin
    irq_id_o = '0;
    for (int i = soc_bus_pkg::IRQ_N - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        irq_id_o = soc_bus_pkg::irq_id_t'(i);
      end
    end
  end

  // Only the bit being acknowledged is cleared
  always_comb begin
    clr = '0;
    if (inta_i) begin
      clr[irq_id_o] = 1'b1;
    end
  end

  // A new edge on the same line in the acknowledge cycle stays pending
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      irq_q  <= '0;
      pend_q <= '0;
    end else begin
      irq_q  <= irq_i;
      pend_q <= (pend_q & ~clr) | rise;
    end
  end

  assign intr_o = |pend_q;

endmodule

`default_nettype wire

// ==== verilog/soc_bus_top.sv ====
// Wishbone system bus top level
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top #(
  parameter int RAM_AW    = 10,                   // RAM is 2**RAM_AW words
  parameter int RST_CNT_W = 17                    // Reset stretch counter width
) (
  input  logic                           clk,
  input  logic                           rst_lck,

  // External master port
  input  soc_bus_pkg::addr_t             wb_adr_i,
  input  logic                           wb_tga_i,
  input  soc_bus_pkg::data_t             wb_dat_i,
  input  soc_bus_pkg::sel_t              wb_sel_i,
  input  logic                           wb_we_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  output soc_bus_pkg::data_t             wb_dat_o,
  output logic                           wb_ack_o,

  // Interrupts
  input  logic [soc_bus_pkg::IRQ_N-1:0]  irq_i,
  input  logic                           inta_i,
  output logic                           intr_o,

  // GPIO pins
  input  logic [9:0]                     sw_i,
  output logic [9:0]                     led_o
);

  logic                 sys_rst;
  logic                 ram_stb;
  logic                 ram_ack;
  logic                 gpio_stb;
  logic                 gpio_ack;
  soc_bus_pkg::data_t   ram_dat;
  soc_bus_pkg::data_t   gpio_dat;
  soc_bus_pkg::irq_id_t irq_id;

  rst_stretch #(
    .RST_CNT_W (RST_CNT_W)
  ) rst_stretch_i (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst)
  );

  wb_addr_decode #(
    .RAM_AW (RAM_AW)
  ) wb_addr_decode_i (
    .clk        (clk),
    .sys_rst_i  (sys_rst),
    .adr_i      (wb_adr_i),
    .tga_i      (wb_tga_i),
    .sel_i      (wb_sel_i),
    .we_i       (wb_we_i),
    .cyc_i      (wb_cyc_i),
    .stb_i      (wb_stb_i),
    .dat_o      (wb_dat_o),
    .ack_o      (wb_ack_o),
    .ram_stb_o  (ram_stb),
    .gpio_stb_o (gpio_stb),
    .ram_dat_i  (ram_dat),
    .ram_ack_i  (ram_ack),
    .gpio_dat_i (gpio_dat),
    .gpio_ack_i (gpio_ack),
    .inta_i     (inta_i),
    .irq_id_i   (irq_id)
  );

  base_ram #(
    .RAM_AW (RAM_AW)
  ) base_ram_i (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .adr_i     (wb_adr_i[RAM_AW-1:0]),            // Upper bits checked by the decoder
    .dat_i     (wb_dat_i),
    .sel_i     (wb_sel_i),
    .we_i      (wb_we_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (ram_stb),
    .dat_o     (ram_dat),
    .ack_o     (ram_ack)
  );

  gpio_port gpio_port_i (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .adr_i     (wb_adr_i[0]),                     // I/O 0xf100 or 0xf102
    .dat_i     (wb_dat_i),
    .sel_i     (wb_sel_i),
    .we_i      (wb_we_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (gpio_stb),
    .dat_o     (gpio_dat),
    .ack_o     (gpio_ack),
    .sw_i      (sw_i),
    .led_o     (led_o)
  );

  int_ctrl int_ctrl_i (
    .clk       (clk),
    .sys_rst_i (sys_rst),
    .irq_i     (irq_i),
    .inta_i    (inta_i),
    .intr_o    (intr_o),
    .irq_id_o  (irq_id)
  );

endmodule

`default_nettype wire

// ==== verif/soc_bus_checker.sv ====
// Bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module soc_bus_checker (
  input  logic clk,
  input  logic sys_rst_i,
  input  logic cyc_i,
  input  logic stb_i,
  input  logic ack_i,
  input  logic intr_i
);

  int fail_cnt = 0;                               // Read by the testbench at the end

  ack_in_cycle: assert property (@(posedge clk) ack_i |-> (cyc_i && stb_i))
    else begin
      fail_cnt++;
      $error("Acknowledge seen without cyc and stb");
    end

  no_ack_in_reset: assert property (@(posedge clk) sys_rst_i |-> !ack_i)
    else begin
      fail_cnt++;
      $error("Acknowledge seen during the stretched reset");
    end

  no_intr_in_reset: assert property (@(posedge clk) sys_rst_i |-> !intr_i)
    else begin
      fail_cnt++;
      $error("Interrupt request raised during the stretched reset");
    end

endmodule

bind soc_bus_top soc_bus_checker chk_i (
  .clk       (clk),
  .sys_rst_i (sys_rst),
  .cyc_i     (wb_cyc_i),
  .stb_i     (wb_stb_i),
  .ack_i     (wb_ack_o),
  .intr_i    (intr_o)
);

`default_nettype wire

// ==== verif/soc_bus_monitor.sv ====
// Bus reference model and scoreboard
`timescale 1ns/1ps
`default_nettype none

module soc_bus_monitor #(
  parameter int RAM_AW = 10
) (
  input  logic                           clk,
  input  logic                           rst_lck_i,
  input  soc_bus_pkg::addr_t             adr_i,
  input  logic                           tga_i,
  input  soc_bus_pkg::data_t             wdat_i,
  input  soc_bus_pkg::sel_t              sel_i,
  input  logic                           we_i,
  input  logic                           cyc_i,
  input  logic                           stb_i,
  input  soc_bus_pkg::data_t             rdat_i,
  input  logic                           ack_i,
  input  logic [soc_bus_pkg::IRQ_N-1:0]  irq_i,
  input  logic                           inta_i,
  input  logic                           intr_i,
  input  logic [9:0]                     sw_i,
  input  logic [9:0]                     led_i,
  input  logic                           done_i,
  output int                             chk_cnt_o,
  output int                             err_cnt_o,
  output logic                           fin_o
);

  localparam int RAM_WORDS = 2**RAM_AW;

  soc_bus_pkg::data_t            shadow_ram [RAM_WORDS];
  logic [9:0]                    shadow_led;
  logic [soc_bus_pkg::IRQ_N-1:0] pend;               // Model of pending requests
  logic [soc_bus_pkg::IRQ_N-1:0] irq_prev;
  logic [soc_bus_pkg::IRQ_N-1:0] clr;
  soc_bus_pkg::data_t            exp;
  int                            wait_cyc;           // Edges a request has waited for ack
  int                            lat;
  logic                          settled;            // First access has waited out the reset

  // GPIO sits at I/O bytes 0xf100 to 0xf103, only the low 16 address bits count
  function automatic logic is_gpio(input logic tga, input soc_bus_pkg::addr_t adr);
    logic [15:0] io_byte;
    io_byte = {adr[14:0], 1'b0};
    return tga && (io_byte[15:2] == 14'(16'hf100 >> 2));
  endfunction

  function automatic logic is_ram(input logic tga, input soc_bus_pkg::addr_t adr);
    return !tga && (int'(adr) < RAM_WORDS);
  endfunction

  function automatic soc_bus_pkg::data_t expected_read(input logic tga,
                                                       input soc_bus_pkg::addr_t adr);
    if (is_ram(tga, adr)) return shadow_ram[adr[RAM_AW-1:0]];
    if (is_gpio(tga, adr)) return adr[0] ? {6'b0, shadow_led} : {6'b0, sw_i};
    return 16'hffff;                                 // Default slave
  endfunction

  function automatic int lowest_index(input logic [soc_bus_pkg::IRQ_N-1:0] bits);
    for (int i = 0; i < soc_bus_pkg::IRQ_N; i++) begin
      if (bits[i]) return i;
    end
    return 0;
  endfunction

  initial begin
    chk_cnt_o = 0;
    err_cnt_o = 0;
    fin_o     = 1'b0;
  end

  always @(posedge clk) begin
    clr = '0;
    if (!rst_lck_i) begin
      pend       = '0;
      irq_prev   = '0;
      shadow_led = '0;
      wait_cyc   = 0;
      settled    = 1'b0;
    end else begin
      if (intr_i !== (pend != '0)) begin
        $display("ERROR at %0t: intr_o is %b, expected %b", $time, intr_i, pend != '0);
        err_cnt_o++;
      end
      // RAM and GPIO add one wait state before ack
      if (cyc_i && stb_i && ack_i) begin
        lat = (is_ram(tga_i, adr_i) || is_gpio(tga_i, adr_i)) ? 1 : 0;
        if (settled && (wait_cyc != lat)) begin
          $display("ERROR at %0t: ack after %0d wait cycles, expected %0d",
                   $time, wait_cyc, lat);
          err_cnt_o++;
        end
        settled  = 1'b1;
        wait_cyc = 0;
      end else if (cyc_i && stb_i) begin
        wait_cyc++;
      end else begin
        wait_cyc = 0;
      end
      if (inta_i) begin
        exp = soc_bus_pkg::VECTOR_BASE + 16'(lowest_index(pend));
        chk_cnt_o++;
        if (rdat_i !== exp) begin
          $display("ERROR at %0t: vector %h, expected %h", $time, rdat_i, exp);
          err_cnt_o++;
        end
        clr[lowest_index(pend)] = 1'b1;
      end else if (cyc_i && stb_i && ack_i && we_i) begin
        for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
          if (sel_i[b] && is_ram(tga_i, adr_i)) begin
            shadow_ram[adr_i[RAM_AW-1:0]][8*b +: 8] = wdat_i[8*b +: 8];
          end
        end
        if (is_gpio(tga_i, adr_i) && adr_i[0]) begin
          if (sel_i[0]) shadow_led[7:0] = wdat_i[7:0];
          if (sel_i[1]) shadow_led[9:8] = wdat_i[9:8];
        end
      end else if (cyc_i && stb_i && ack_i) begin
        exp = expected_read(tga_i, adr_i);
        chk_cnt_o++;
        if (rdat_i !== exp) begin
          $display("ERROR at %0t: read tga %b adr %h gave %h, expected %h",
                   $time, tga_i, adr_i, rdat_i, exp);
          err_cnt_o++;
        end
        if (is_gpio(tga_i, adr_i) && (led_i !== shadow_led)) begin
          $display("ERROR at %0t: led_o %h, expected %h", $time, led_i, shadow_led);
          err_cnt_o++;
        end
      end
      pend     = (pend & ~clr) | (irq_i & ~irq_prev);
      irq_prev = irq_i;
    end
    if (done_i && !fin_o) begin
      if (pend != '0) begin
        $display("Interrupts %b were still pending at the end of the run", pend);
        err_cnt_o++;
      end
      fin_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_soc_bus.sv ====
// System bus testbench
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

  localparam int RAM_AW    = 10;
  localparam int RST_CNT_W = 4;
  localparam int TIMEOUT   = 100;                 // Cycles per wait
  localparam int N_WORDS   = 8;
  localparam soc_bus_pkg::addr_t SW_ADR  = 19'(16'hf100 >> 1);
  localparam soc_bus_pkg::addr_t LED_ADR = 19'(16'hf102 >> 1);

  logic                          clk = 1'b0;
  logic                          rst_lck;
  soc_bus_pkg::addr_t            wb_adr;
  logic                          wb_tga;
  soc_bus_pkg::data_t            wb_wdat;
  soc_bus_pkg::sel_t             wb_sel;
  logic                          wb_we;
  logic                          wb_cyc;
  logic                          wb_stb;
  soc_bus_pkg::data_t            wb_rdat;
  logic                          wb_ack;
  logic [soc_bus_pkg::IRQ_N-1:0] irq;
  logic                          inta;
  logic                          intr;
  logic [9:0]                    sw;
  logic [9:0]                    led;
  logic                          done;
  logic                          fin;
  logic                          in_stretch = 1'b0;
  int                            chk_cnt;
  int                            mon_err;
  int                            tb_err = 0;
  int                            tmo_cnt = 0;
  integer                        seed = 32'h1d410268;

  always #5 clk = ~clk;

  soc_bus_top #(.RAM_AW(RAM_AW), .RST_CNT_W(RST_CNT_W)) dut_i (
    .clk(clk), .rst_lck(rst_lck),
    .wb_adr_i(wb_adr), .wb_tga_i(wb_tga), .wb_dat_i(wb_wdat), .wb_sel_i(wb_sel),
    .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
    .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
    .irq_i(irq), .inta_i(inta), .intr_o(intr), .sw_i(sw), .led_o(led)
  );

  soc_bus_monitor #(.RAM_AW(RAM_AW)) mon_i (
    .clk(clk), .rst_lck_i(rst_lck), .adr_i(wb_adr), .tga_i(wb_tga), .wdat_i(wb_wdat),
    .sel_i(wb_sel), .we_i(wb_we), .cyc_i(wb_cyc), .stb_i(wb_stb), .rdat_i(wb_rdat),
    .ack_i(wb_ack), .irq_i(irq), .inta_i(inta), .intr_i(intr), .sw_i(sw), .led_i(led),
    .done_i(done), .chk_cnt_o(chk_cnt), .err_cnt_o(mon_err), .fin_o(fin)
  );

  always @(posedge clk) begin
    if (in_stretch && (led !== '0 || intr !== 1'b0)) begin
      $display("ERROR at %0t: led_o %h intr_o %b not low in reset", $time, led, intr);
      tb_err++;
    end
  end

  // One classic cycle, held until ack
  task automatic bus_cycle(input logic tga, input soc_bus_pkg::addr_t adr,
                           input soc_bus_pkg::data_t dat, input soc_bus_pkg::sel_t sel,
                           input logic we, output int cycles);
    int n;
    n = 0;
    @(posedge clk);
    wb_tga  <= tga;
    wb_adr  <= adr;
    wb_wdat <= dat;
    wb_sel  <= sel;
    wb_we   <= we;
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    do begin
      @(posedge clk);
      n++;
    end while (wb_ack !== 1'b1 && n < TIMEOUT);
    if (wb_ack !== 1'b1) begin
      $display("Timed out waiting for the bus acknowledge at address %h", adr);
      tmo_cnt++;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    cycles = n;
  endtask

  task automatic wait_intr(input logic level);
    int n;
    n = 0;
    while (intr !== level && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (intr !== level) begin
      $display("Timed out waiting for intr_o to become %b", level);
      tmo_cnt++;
    end
  endtask

  task automatic ack_interrupt();
    @(posedge clk);
    inta <= 1'b1;
    @(posedge clk);
    inta <= 1'b0;
  endtask

  initial begin
    int                 cycles;
    int                 n;
    soc_bus_pkg::addr_t ram_adr [N_WORDS];
    soc_bus_pkg::data_t val;
    soc_bus_pkg::sel_t  sel;
    rst_lck = 1'b0;
    wb_adr  = '0;
    wb_tga  = 1'b0;
    wb_wdat = '0;
    wb_sel  = '0;
    wb_we   = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    irq     = '0;
    inta    = 1'b0;
    sw      = '0;
    done    = 1'b0;
    repeat (3) @(posedge clk);
    rst_lck    <= 1'b1;
    in_stretch <= 1'b1;
    bus_cycle(1'b1, LED_ADR, '0, 2'b11, 1'b0, cycles);  // Held off by the stretch
    in_stretch <= 1'b0;
    if (cycles <= 15) begin
      $display("ERROR at %0t: ack after %0d cycles of stretched reset", $time, cycles);
      tb_err++;
    end
    // Full words first so every byte is known
    for (int i = 0; i < N_WORDS; i++) begin
      ram_adr[i] = soc_bus_pkg::addr_t'($random(seed) & (2**RAM_AW - 1));
      bus_cycle(1'b0, ram_adr[i], 16'($random(seed)), 2'b11, 1'b1, cycles);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      sel = 2'($random(seed));
      if (sel == '0) sel = 2'b10;
      bus_cycle(1'b0, ram_adr[i], 16'($random(seed)), sel, 1'b1, cycles);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      bus_cycle(1'b0, ram_adr[i], '0, 2'b11, 1'b0, cycles);
    end
    @(posedge clk);
    sw <= 10'($random(seed));
    bus_cycle(1'b1, SW_ADR, '0, 2'b11, 1'b0, cycles);
    val = 16'($random(seed)) & 16'h03ff;
    bus_cycle(1'b1, LED_ADR, val, 2'b11, 1'b1, cycles);
    if (led !== val[9:0]) begin
      $display("ERROR at %0t: led_o %h after writing %h", $time, led, val[9:0]);
      tb_err++;
    end
    bus_cycle(1'b1, LED_ADR, '0, 2'b11, 1'b0, cycles);
    bus_cycle(1'b1, 19'h00010, '0, 2'b11, 1'b0, cycles);          // I/O 0x0020
    bus_cycle(1'b1, 19'h07882, '0, 2'b11, 1'b0, cycles);          // I/O 0xf104
    bus_cycle(1'b0, ram_adr[0] | 19'h00400, '0, 2'b11, 1'b0, cycles);
    bus_cycle(1'b0, ram_adr[0] | 19'h40000, ~val, 2'b11, 1'b1, cycles);
    bus_cycle(1'b0, ram_adr[0], '0, 2'b11, 1'b0, cycles);         // Must be unchanged
    @(posedge clk);
    irq <= 8'b0110_0100;
    @(posedge clk);
    irq <= '0;
    wait_intr(1'b1);
    ack_interrupt();
    irq <= 8'b0000_0001;                                          // Outranks the rest
    @(posedge clk);
    irq <= '0;
    repeat (3) ack_interrupt();
    wait_intr(1'b0);
    @(posedge clk);
    done <= 1'b1;
    n = 0;
    while (fin !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (fin !== 1'b1) begin
      $display("Timed out waiting for the monitor to finish");
      tmo_cnt++;
    end
    $display("Checked %0d, monitor errors %0d, testbench errors %0d, timeouts %0d, asserts %0d",
             chk_cnt, mon_err, tb_err, tmo_cnt, dut_i.chk_i.fail_cnt);
    if (mon_err + tb_err + tmo_cnt + dut_i.chk_i.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/soc_bus_pkg.sv
verilog/rst_stretch.sv
verilog/wb_addr_decode.sv
verilog/base_ram.sv
verilog/gpio_port.sv
verilog/int_ctrl.sv
verilog/soc_bus_top.sv
verif/soc_bus_checker.sv
verif/soc_bus_monitor.sv
verif/tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - verilog/soc_bus_pkg.sv
  - verilog/rst_stretch.sv
  - verilog/wb_addr_decode.sv
  - verilog/base_ram.sv
  - verilog/gpio_port.sv
  - verilog/int_ctrl.sv
  - verilog/soc_bus_top.sv
  - target: test
    files:
      - verif/soc_bus_checker.sv
      - verif/soc_bus_monitor.sv
      - verif/tb_soc_bus.sv
